/* Makefile */
TOP = tb_interconnect

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* bench/tb_interconnect.sv */
/*
 * Testbench for the inner interconnect
 * Drives both cores and their sr buses, checks with concurrent assertions
 */

`timescale 1ns/1ps

`include "interconnect_consts.svh"

module tb_interconnect;

    import interconnect_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_CYCLES = 2000;

    logic           i_clk;
    logic           i_reset;
    logic           i_disable;
    wb_req_t        req [2];
    sr_bus_t        sr [2];
    wb_rsp_t        rsp [2];
    wb_req_t        outer_req;
    wb_rsp_t        outer_rsp;
    logic [`RW-1:0] o_c0_sreg;
    logic [`RW-1:0] o_c1_sreg;
    logic           o_c0_core_int;
    logic           o_c1_core_int;
    logic           o_c0_disable;
    logic           o_c1_disable;

    // Expected state kept from the bus rules
    logic [11:0]    frame_sh [2][16];
    logic           pg_en_sh [2];
    logic [`RW-1:0] exp_mem [1024];
    logic [`RW-1:0] exp_dat [2];
    logic           exp_err [2];
    logic [1:0]     owner;
    logic           last_m1;
    logic [23:0]    exp_adr;
    int             errors;

    interconnect_inner UUT (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_c0_req(req[0]), .i_c1_req(req[1]), .o_c0_rsp(rsp[0]), .o_c1_rsp(rsp[1]),
        .i_c0_sr(sr[0]), .i_c1_sr(sr[1]), .o_wb_req(outer_req), .i_wb_rsp(outer_rsp),
        .i_disable(i_disable), .o_c0_sreg(o_c0_sreg), .o_c1_sreg(o_c1_sreg),
        .o_c0_core_int(o_c0_core_int), .o_c1_core_int(o_c1_core_int),
        .o_c0_disable(o_c0_disable), .o_c1_disable(o_c1_disable)
    );

    wb_slave_model slave (.i_clk(i_clk), .i_reset(i_reset), .i_req(outer_req), .o_rsp(outer_rsp));

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [23:0] translate(int c, logic [15:0] vaddr);
        if (pg_en_sh[c]) begin
            return {frame_sh[c][vaddr[15:12]], vaddr[11:0]};
        end
        return {8'h00, vaddr};
    endfunction

    task automatic count_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
    endtask

    task automatic note_failure(string what);
        errors++;
        $display("[ERROR] %s", what);
    endtask

    ////////////////////////////////
    // Expected grant owner
    ////////////////////////////////

    always @(posedge i_clk) begin
        if (i_reset) begin
            owner   <= 2'd0;
            last_m1 <= 1'b1;
        end else if (owner == 2'd0) begin
            if (req[0].cyc && req[1].cyc) begin
                owner <= last_m1 ? 2'd1 : 2'd2;
            end else if (req[0].cyc) begin
                owner <= 2'd1;
            end else if (req[1].cyc) begin
                owner <= 2'd2;
            end
        end else if (outer_rsp.ack || outer_rsp.err) begin
            last_m1 <= (owner == 2'd2);
            owner   <= 2'd0;
        end
    end

    always_comb begin
        exp_adr = (owner == 2'd2) ? translate(1, req[1].adr[15:0]) : translate(0, req[0].adr[15:0]);
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    a_outer_adr: assert property (@(posedge i_clk) disable iff (i_reset)
        owner != 2'd0 |-> outer_req.cyc && outer_req.adr == exp_adr)
        else count_mismatch("outer_adr", $sampled(exp_adr), $sampled(outer_req.adr));
    a_outer_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        owner == 2'd0 |-> !outer_req.cyc)
        else note_failure("outer cyc high with no master granted");
    a_grant_delay: assert property (@(posedge i_clk) disable iff (i_reset)
        owner == 2'd0 && (req[0].cyc || req[1].cyc) |=> outer_req.cyc)
        else note_failure("outer cyc did not rise one cycle after a request in idle");
    a_rsp0_owner: assert property (@(posedge i_clk) disable iff (i_reset)
        (rsp[0].ack || rsp[0].err) |-> req[0].cyc && owner == 2'd1)
        else note_failure("core 0 answered outside its own granted cycle");
    a_rsp1_owner: assert property (@(posedge i_clk) disable iff (i_reset)
        (rsp[1].ack || rsp[1].err) |-> req[1].cyc && owner == 2'd2)
        else note_failure("core 1 answered outside its own granted cycle");
    a_rd0: assert property (@(posedge i_clk) disable iff (i_reset)
        rsp[0].ack && !req[0].we |-> rsp[0].dat == exp_dat[0])
        else count_mismatch("read_c0", $sampled(exp_dat[0]), $sampled(rsp[0].dat));
    a_rd1: assert property (@(posedge i_clk) disable iff (i_reset)
        rsp[1].ack && !req[1].we |-> rsp[1].dat == exp_dat[1])
        else count_mismatch("read_c1", $sampled(exp_dat[1]), $sampled(rsp[1].dat));
    a_err0: assert property (@(posedge i_clk) disable iff (i_reset)
        (rsp[0].ack || rsp[0].err) |-> rsp[0].err == exp_err[0])
        else count_mismatch("err_c0", $sampled(exp_err[0]), $sampled(rsp[0].err));
    a_err1: assert property (@(posedge i_clk) disable iff (i_reset)
        (rsp[1].ack || rsp[1].err) |-> rsp[1].err == exp_err[1])
        else count_mismatch("err_c1", $sampled(exp_err[1]), $sampled(rsp[1].err));
    a_mbox: assert property (@(posedge i_clk) disable iff (i_reset)
        sr[0].we && sr[0].addr == `SR_MAILBOX |=> o_c1_core_int && o_c1_sreg == $past(sr[0].data))
        else count_mismatch("mailbox_c1", $past(sr[0].data), $sampled(o_c1_sreg));
    a_mbox_c0: assert property (@(posedge i_clk) disable iff (i_reset)
        sr[1].we && sr[1].addr == `SR_MAILBOX |=> o_c0_core_int && o_c0_sreg == $past(sr[1].data))
        else count_mismatch("mailbox_c0", $past(sr[1].data), $sampled(o_c0_sreg));
    a_int_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        sr[1].we && sr[1].addr == `SR_INT_ACK && !(sr[0].we && sr[0].addr == `SR_MAILBOX)
        |=> !o_c1_core_int)
        else note_failure("core 1 interrupt stayed high after its acknowledge");
    a_int_ack_c0: assert property (@(posedge i_clk) disable iff (i_reset)
        sr[0].we && sr[0].addr == `SR_INT_ACK && !(sr[1].we && sr[1].addr == `SR_MAILBOX)
        |=> !o_c0_core_int)
        else note_failure("core 0 interrupt stayed high after its acknowledge");
    a_dis_c0: assert property (@(posedge i_clk) disable iff (i_reset)
        sr[0].we && sr[0].addr == `SR_CORE_DISABLE && !i_disable
        |=> o_c1_disable == $past(sr[0].data[0]))
        else count_mismatch("disable_c1", $past(sr[0].data[0]), $sampled(o_c1_disable));
    a_dis_c1: assert property (@(posedge i_clk) disable iff (i_reset)
        sr[1].we && sr[1].addr == `SR_CORE_DISABLE && !(sr[0].we && sr[0].addr == `SR_CORE_DISABLE)
        && !i_disable |=> $stable(o_c1_disable))
        else note_failure("core 1 changed its own disable bit");
    a_dis_force: assert property (@(posedge i_clk)
        i_disable |-> o_c0_disable && o_c1_disable)
        else note_failure("external disable did not force both cores off");
    a_c0_enabled: assert property (@(posedge i_clk)
        !i_disable |-> !o_c0_disable)
        else note_failure("core 0 disabled without the external input");

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    task automatic sr_write(int c, logic [7:0] addr, logic [15:0] data);
        @(posedge i_clk);
        #1;
        sr[c] = '{we: 1'b1, addr: addr, data: data};
        @(posedge i_clk);
        if (addr == `SR_PAGE_EN) pg_en_sh[c] = data[0];
        if (addr[7:4] == 4'h1) frame_sh[c][addr[3:0]] = data[11:0];
        #1;
        sr[c] = '0;
    endtask

    task automatic core_access(int c, logic [15:0] vaddr, logic we, logic [15:0] data);
        logic [23:0] phys;
        phys       = translate(c, vaddr);
        exp_err[c] = (phys[23:20] == 4'hF);
        exp_dat[c] = exp_mem[phys[9:0]];
        @(posedge i_clk);
        #1;
        req[c] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: {8'h00, vaddr}, dat: data, sel: 2'b11};
        do begin
            @(posedge i_clk);
        end while (!(rsp[c].ack || rsp[c].err));
        if (we && !exp_err[c]) exp_mem[phys[9:0]] = data;
        #1;
        req[c] = '0;
    endtask

    initial begin
        void'($urandom(32'h2d4798d8));
        errors    = 0;
        i_reset   = 1'b1;
        i_disable = 1'b0;
        req[0]    = '0;
        req[1]    = '0;
        sr[0]     = '0;
        sr[1]     = '0;
        for (int c = 0; c < 2; c++) begin
            pg_en_sh[c] = 1'b0;
            exp_dat[c]  = '0;
            exp_err[c]  = 1'b0;
            for (int p = 0; p < 16; p++) frame_sh[c][p] = '0;
        end
        for (int i = 0; i < 1024; i++) exp_mem[i] = i[15:0] ^ 16'h5A5A;
        repeat (16) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Paging off, write then read back, untouched reads
        for (int k = 0; k < 4; k++) begin
            core_access(k % 2, 16'h0100 + 16'(k * 2), 1'b1, 16'($urandom));
            core_access(k % 2, 16'h0100 + 16'(k * 2), 1'b0, '0);
            core_access(k % 2, 16'($urandom) & 16'h7FFF, 1'b0, '0);
        end

        // Paging on for core 0 only
        sr_write(0, `SR_PAGE_BASE + 8'd3, 16'h123);
        sr_write(0, `SR_PAGE_EN, 16'h0001);
        core_access(0, 16'h3000 | (16'($urandom) & 16'h0FFF), 1'b0, '0);
        core_access(1, 16'h3000 | (16'($urandom) & 16'h0FFF), 1'b0, '0);

        // Both cores at once, grants alternate
        for (int k = 0; k < 6; k++) begin
            fork
                core_access(0, 16'h3200 + 16'(k), 1'b1, 16'($urandom));
                core_access(1, 16'h0400 + 16'(k), 1'b0, '0);
            join
        end

        // Error region for core 0 while core 1 reads normally
        sr_write(0, `SR_PAGE_BASE + 8'd5, 16'h0F00);
        fork
            core_access(0, 16'h5010, 1'b0, '0);
            core_access(1, 16'h0010, 1'b0, '0);
        join

        // Mailbox both ways and acknowledges
        sr_write(0, `SR_MAILBOX, 16'($urandom));
        sr_write(1, `SR_INT_ACK, 16'h0000);
        sr_write(1, `SR_MAILBOX, 16'($urandom));
        sr_write(0, `SR_INT_ACK, 16'h0000);

        // Post and acknowledge in the same cycle
        fork
            sr_write(0, `SR_MAILBOX, 16'($urandom));
            sr_write(1, `SR_INT_ACK, 16'h0000);
        join
        sr_write(1, `SR_INT_ACK, 16'h0000);

        // Disable control
        sr_write(0, `SR_CORE_DISABLE, 16'h0001);
        sr_write(1, `SR_CORE_DISABLE, 16'h0000);
        sr_write(0, `SR_CORE_DISABLE, 16'h0000);
        @(posedge i_clk);
        #1;
        i_disable = 1'b1;
        repeat (4) @(posedge i_clk);
        #1;
        i_disable = 1'b0;
        repeat (4) @(posedge i_clk);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* bench/wb_slave_model.sv */
/*
 * Outer Wishbone memory model
 * 1024 words, ack two cycles after stb, err for the 0xF00000 region
 */

`timescale 1ns/1ps

`include "interconnect_consts.svh"

module wb_slave_model (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  interconnect_pkg::wb_req_t i_req,
    output interconnect_pkg::wb_rsp_t o_rsp
);

    import interconnect_pkg::*;

    logic [`RW-1:0] mem [1024];
    logic [1:0]     wait_cnt;
    logic           ack_q;
    logic           err_q;
    logic [`RW-1:0] dat_q;
    logic           in_err_region;
    logic [9:0]     idx;

    assign in_err_region = (i_req.adr[23:20] == 4'hF);
    assign idx           = i_req.adr[9:0];

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = i[15:0] ^ 16'h5A5A;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            dat_q    <= '0;
        end else if (i_req.cyc && i_req.stb && !ack_q && !err_q) begin
            if (wait_cnt == 2'd1) begin
                wait_cnt <= '0;
                ack_q    <= !in_err_region;
                err_q    <= in_err_region;
                dat_q    <= mem[idx];
                if (i_req.we && !in_err_region) begin
                    if (i_req.sel[0]) mem[idx][7:0] <= i_req.dat[7:0];
                    if (i_req.sel[1]) mem[idx][15:8] <= i_req.dat[15:8];
                end
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            // Answer lasts one cycle
            wait_cnt <= '0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
        end
    end

    assign o_rsp = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

/* flist.f */
+incdir+hdl
hdl/interconnect_pkg.sv
hdl/page_mmu.sv
hdl/wb_arbiter.sv
hdl/intercore_sregs.sv
hdl/interconnect_inner.sv
bench/wb_slave_model.sv
bench/tb_interconnect.sv

/* hdl/interconnect_consts.svh */
/*
 * Inner interconnect constants
 * Bus widths, page table geometry and sr-bus register map
 */

`ifndef INTERCONNECT_CONSTS_SVH
`define INTERCONNECT_CONSTS_SVH

// Bus widths
`define RW              16
`define WB_ADDR_W       24
`define WB_SEL_BITS     2

// Page table geometry, 16 entries of 4 KiB-word pages
`define PAGE_BITS       4
`define PAGE_OFS_BITS   12

// Special-register bus map
`define SR_PAGE_EN      8'h08
`define SR_PAGE_BASE    8'h10
`define SR_MAILBOX      8'h20
`define SR_INT_ACK      8'h21
`define SR_CORE_DISABLE 8'h22

`endif

/* hdl/interconnect_inner.sv */
/*
 * Inner interconnect of the dual-core system
 * Per-core MMUs feed a round-robin arbiter onto the outer Wishbone bus,
 * intercore registers sit beside them on the sr buses
 */

`timescale 1ns/1ps

`include "interconnect_consts.svh"

module interconnect_inner (
    input  logic                      i_clk,
    input  logic                      i_reset,

    // Core data ports, virtual addresses
    input  interconnect_pkg::wb_req_t i_c0_req,
    input  interconnect_pkg::wb_req_t i_c1_req,
    output interconnect_pkg::wb_rsp_t o_c0_rsp,
    output interconnect_pkg::wb_rsp_t o_c1_rsp,

    // Core sr buses
    input  interconnect_pkg::sr_bus_t i_c0_sr,
    input  interconnect_pkg::sr_bus_t i_c1_sr,

    // Outer Wishbone bus
    output interconnect_pkg::wb_req_t o_wb_req,
    input  interconnect_pkg::wb_rsp_t i_wb_rsp,

    // Intercore control
    input  logic                      i_disable,
    output logic [`RW-1:0]            o_c0_sreg,
    output logic [`RW-1:0]            o_c1_sreg,
    output logic                      o_c0_core_int,
    output logic                      o_c1_core_int,
    output logic                      o_c0_disable,
    output logic                      o_c1_disable
);

    import interconnect_pkg::*;

    wb_req_t c0_req_phys;
    wb_req_t c1_req_phys;

    //////////////////////////////
    // Address translation
    //////////////////////////////

    page_mmu mmu_0 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_sr    (i_c0_sr),
        .i_req   (i_c0_req),
        .o_req   (c0_req_phys)
    );

    page_mmu mmu_1 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_sr    (i_c1_sr),
        .i_req   (i_c1_req),
        .o_req   (c1_req_phys)
    );

    //////////////////////////////
    // Outer bus arbitration
    //////////////////////////////

    wb_arbiter arbiter (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_m0     (c0_req_phys),
        .i_m1     (c1_req_phys),
        .o_m0_rsp (o_c0_rsp),
        .o_m1_rsp (o_c1_rsp),
        .o_wb_req (o_wb_req),
        .i_wb_rsp (i_wb_rsp)
    );

    // Intercore control
    intercore_sregs icore_sregs (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_c0_sr       (i_c0_sr),
        .i_c1_sr       (i_c1_sr),
        .i_disable     (i_disable),
        .o_c0_sreg     (o_c0_sreg),
        .o_c1_sreg     (o_c1_sreg),
        .o_c0_core_int (o_c0_core_int),
        .o_c1_core_int (o_c1_core_int),
        .o_c0_disable  (o_c0_disable),
        .o_c1_disable  (o_c1_disable)
    );

endmodule

/* hdl/interconnect_pkg.sv */
/*
 * Inner interconnect types
 * Wishbone request/response bundles, sr-bus write and arbiter state
 */

`include "interconnect_consts.svh"

package interconnect_pkg;

    // Master side of one Wishbone cycle
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`WB_ADDR_W-1:0]   adr;
        logic [`RW-1:0]          dat;
        logic [`WB_SEL_BITS-1:0] sel;
    } wb_req_t;

    // Slave answer, ack or err ends the cycle
    typedef struct packed {
        logic           ack;
        logic           err;
        logic [`RW-1:0] dat;
    } wb_rsp_t;

    // One core's special-register write
    typedef struct packed {
        logic           we;
        logic [7:0]     addr;
        logic [`RW-1:0] data;
    } sr_bus_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GNT0,
        ARB_GNT1
    } arb_state_t;

endpackage

/* hdl/intercore_sregs.sv */
/*
 * Intercore special registers
 * Per-core mailbox with peer interrupt, interrupt acknowledge,
 * and core 0 control over core 1's disable
 */

`timescale 1ns/1ps

`include "interconnect_consts.svh"

module intercore_sregs (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  interconnect_pkg::sr_bus_t i_c0_sr,
    input  interconnect_pkg::sr_bus_t i_c1_sr,
    input  logic                      i_disable,
    output logic [`RW-1:0]            o_c0_sreg,
    output logic [`RW-1:0]            o_c1_sreg,
    output logic                      o_c0_core_int,
    output logic                      o_c1_core_int,
    output logic                      o_c0_disable,
    output logic                      o_c1_disable
);

    import interconnect_pkg::*;

    sr_bus_t        sr [2];
    logic [1:0]     mbox_wr;
    logic [1:0]     ack_wr;
    logic [`RW-1:0] mbox_q [2];
    logic [1:0]     int_q;
    logic           c1_dis_q;

    assign sr[0] = i_c0_sr;
    assign sr[1] = i_c1_sr;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            mbox_wr[i] = sr[i].we && (sr[i].addr == `SR_MAILBOX);
            ack_wr[i]  = sr[i].we && (sr[i].addr == `SR_INT_ACK);
        end
    end

    //////////////////////////////
    // Mailbox and interrupts
    //////////////////////////////

    // A peer write in the same cycle as the acknowledge wins
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            int_q    <= '0;
            c1_dis_q <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (mbox_wr[1-i]) begin
                    int_q[i] <= 1'b1;
                end else if (ack_wr[i]) begin
                    int_q[i] <= 1'b0;
                end
            end
            if (i_c0_sr.we && i_c0_sr.addr == `SR_CORE_DISABLE) begin
                c1_dis_q <= i_c0_sr.data[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < 2; i++) begin
            if (mbox_wr[1-i]) begin
                mbox_q[i] <= sr[1-i].data;
            end
        end
    end

    assign o_c0_sreg     = mbox_q[0];
    assign o_c1_sreg     = mbox_q[1];
    assign o_c0_core_int = int_q[0];
    assign o_c1_core_int = int_q[1];

    // Core 0 has no disable bit of its own
    assign o_c0_disable = i_disable;
    assign o_c1_disable = c1_dis_q | i_disable;

endmodule

/* hdl/page_mmu.sv */
/*
 * Page MMU
 * Maps a 16-bit virtual address onto the 24-bit physical bus through a
 * 16-entry frame table loaded over the core's sr bus
 */

`timescale 1ns/1ps

`include "interconnect_consts.svh"

module page_mmu (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  interconnect_pkg::sr_bus_t i_sr,
    input  interconnect_pkg::wb_req_t i_req,
    output interconnect_pkg::wb_req_t o_req
);

    localparam int FRAME_W = `WB_ADDR_W - `PAGE_OFS_BITS;
    localparam int PAGES = 1 << `PAGE_BITS;
    localparam logic [7:0] PAGE_BASE = `SR_PAGE_BASE;

    logic [FRAME_W-1:0]        frame_q [PAGES];
    logic                      paging_en_q;
    logic                      entry_wr;
    logic                      en_wr;
    logic [`PAGE_BITS-1:0]     entry_idx;
    logic [`PAGE_BITS-1:0]     vpage;
    logic [`PAGE_OFS_BITS-1:0] vofs;

    //////////////////////////////
    // Table writes
    //////////////////////////////

    // Upper address nibble selects the table window
    assign entry_wr  = i_sr.we && (i_sr.addr[7:`PAGE_BITS] == PAGE_BASE[7:`PAGE_BITS]);
    assign en_wr     = i_sr.we && (i_sr.addr == `SR_PAGE_EN);
    assign entry_idx = i_sr.addr[`PAGE_BITS-1:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            paging_en_q <= 1'b0;
            for (int i = 0; i < PAGES; i++) begin
                frame_q[i] <= '0;
            end
        end else begin
            if (en_wr) begin
                paging_en_q <= i_sr.data[0];
            end
            if (entry_wr) begin
                frame_q[entry_idx] <= i_sr.data[FRAME_W-1:0];
            end
        end
    end

    //////////////////////////////
    // Translation
    //////////////////////////////

    assign vpage = i_req.adr[`PAGE_OFS_BITS +: `PAGE_BITS];
    assign vofs  = i_req.adr[`PAGE_OFS_BITS-1:0];

    always_comb begin
        o_req = i_req;
        if (paging_en_q) begin
            o_req.adr = {frame_q[vpage], vofs};
        end else begin
            o_req.adr = {{(`WB_ADDR_W - `RW){1'b0}}, i_req.adr[`RW-1:0]};
        end
    end

    // Software must not load frames wider than the physical bus allows
    a_frame_fits: assert property (
        @(posedge i_clk) disable iff (i_reset)
        entry_wr |-> (i_sr.data[`RW-1:FRAME_W] == '0)
    ) else $error("page entry write carries bits above the frame width");

endmodule

/* hdl/wb_arbiter.sv */
/*
 * Two-master Wishbone arbiter
 * Round-robin grant, held from cyc until the slave answers with ack or err
 */

`timescale 1ns/1ps

module wb_arbiter (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  interconnect_pkg::wb_req_t i_m0,
    input  interconnect_pkg::wb_req_t i_m1,
    output interconnect_pkg::wb_rsp_t o_m0_rsp,
    output interconnect_pkg::wb_rsp_t o_m1_rsp,
    output interconnect_pkg::wb_req_t o_wb_req,
    input  interconnect_pkg::wb_rsp_t i_wb_rsp
);

    import interconnect_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       last_m1_q;
    logic       cycle_end;
    logic [1:0] gnt;

    assign cycle_end = i_wb_rsp.ack | i_wb_rsp.err;
    assign gnt       = {state_q == ARB_GNT1, state_q == ARB_GNT0};

    //////////////////////////////
    // Grant FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (i_m0.cyc && i_m1.cyc) begin
                    // Both pending, the one not served last goes first
                    state_d = last_m1_q ? ARB_GNT0 : ARB_GNT1;
                end else if (i_m0.cyc) begin
                    state_d = ARB_GNT0;
                end else if (i_m1.cyc) begin
                    state_d = ARB_GNT1;
                end
            end
            ARB_GNT0, ARB_GNT1: begin
                if (cycle_end) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q   <= ARB_IDLE;
            last_m1_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == ARB_GNT0 && cycle_end) begin
                last_m1_q <= 1'b0;
            end else if (state_q == ARB_GNT1 && cycle_end) begin
                last_m1_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Bus routing
    //////////////////////////////

    always_comb begin
        case (state_q)
            ARB_GNT0: o_wb_req = i_m0;
            ARB_GNT1: o_wb_req = i_m1;
            default:  o_wb_req = '0;
        endcase
    end

    // Answer only the granted master
    assign o_m0_rsp = gnt[0] ? i_wb_rsp : '0;
    assign o_m1_rsp = gnt[1] ? i_wb_rsp : '0;

    // The granted master keeps its cycle open until the answer
    a_gnt_held: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (gnt & {i_m1.cyc, i_m0.cyc}) == gnt
    ) else $error("granted master dropped cyc before the answer");

    // Slave stays quiet while no cycle is open
    a_idle_quiet: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (state_q == ARB_IDLE) |-> !cycle_end
    ) else $error("slave answered while arbiter idle");

endmodule
